// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

  // log2 of the prefetch buffer size.
  localparam int PF_DEPTH = 3;
  localparam int PF_ENTRIES = 2 ** PF_DEPTH;

  // byte address as seen by the core and the memory.
  typedef logic [31:0] addr_t;

  // memory word, also the width of a returned parcel.
  typedef logic [31:0] word_t;

  // word address, the byte address without its two low bits.
  typedef logic [29:0] tag_t;

  typedef logic [PF_DEPTH-1:0] idx_t;

  // fill credit in halfwords.
  typedef logic [2*PF_DEPTH-1:0] credit_t;

  // halfwords consumed per delivered parcel, 1 or 2.
  typedef logic [1:0] step_t;

  typedef enum logic {
    RUN,
    FENCE
  } ctrl_state_t;

endpackage

// ==== hw/pf_wr_if.sv ====
`timescale 1ns/1ns

interface pf_wr_if;

  logic              wren;
  fetch_pkg::idx_t   widx;
  logic              wvalid;
  fetch_pkg::tag_t   wtag;
  fetch_pkg::word_t  wword;

  modport master (output wren, output widx, output wvalid, output wtag, output wword);

  modport target (input wren, input widx, input wvalid, input wtag, input wword);

  // same-cycle view of the write for the bypass path.
  modport monitor (input wren, input widx, input wvalid, input wtag, input wword);

endinterface

// ==== hw/pf_rd_if.sv ====
`timescale 1ns/1ns

interface pf_rd_if;

  fetch_pkg::idx_t   ridx;
  logic              valid1;
  fetch_pkg::tag_t   tag1;
  fetch_pkg::word_t  word1;
  // entry after ridx, wrapping at the end of the buffer.
  logic              valid2;
  fetch_pkg::tag_t   tag2;
  fetch_pkg::word_t  word2;

  modport reader (
    output ridx,
    input valid1, input tag1, input word1, input valid2, input tag2, input word2
  );

  modport store (
    input ridx,
    output valid1, output tag1, output word1, output valid2, output tag2, output word2
  );

endinterface

// ==== hw/prefetch_buffer.sv ====
`timescale 1ns/1ns

module prefetch_buffer (
  input logic     clk,
  input logic     rst,
  pf_wr_if.target wr,
  pf_rd_if.store  rd
);

  logic [fetch_pkg::PF_ENTRIES-1:0] entry_valid;
  fetch_pkg::tag_t                  entry_tag [fetch_pkg::PF_ENTRIES];
  fetch_pkg::word_t                 entry_word [fetch_pkg::PF_ENTRIES];
  fetch_pkg::idx_t                  ridx_next;

  // valid bits only, tags and words follow them.
  always_ff @(posedge clk) begin
    if (!rst) begin
      entry_valid <= '0;
    end else if (wr.wren) begin
      entry_valid[wr.widx] <= wr.wvalid;
    end
  end

  always_ff @(posedge clk) begin
    if (wr.wren) begin
      entry_tag[wr.widx] <= wr.wtag;
      entry_word[wr.widx] <= wr.wword;
    end
  end

  // wraps to entry 0 past the last index.
  assign ridx_next = rd.ridx + fetch_pkg::idx_t'(1);

  assign rd.valid1 = entry_valid[rd.ridx];
  assign rd.tag1 = entry_tag[rd.ridx];
  assign rd.word1 = entry_word[rd.ridx];

  assign rd.valid2 = entry_valid[ridx_next];
  assign rd.tag2 = entry_tag[ridx_next];
  assign rd.word2 = entry_word[ridx_next];

  write_in_range: assert property (@(posedge clk) disable iff (!rst)
    wr.wren |-> (int'(wr.widx) < fetch_pkg::PF_ENTRIES));

endmodule

// ==== hw/fetch_aligner.sv ====
`timescale 1ns/1ns

module fetch_aligner (
  input  fetch_pkg::addr_t paddr,
  pf_rd_if.reader          rd,
  pf_wr_if.monitor         byp,
  output logic             hit1,
  output logic             hit2,
  output logic             parcel_ok,
  output fetch_pkg::step_t step,
  output fetch_pkg::word_t parcel
);

  fetch_pkg::tag_t  tag_a;
  fetch_pkg::tag_t  tag_b;
  logic             byp1;
  logic             byp2;
  logic             stored1;
  logic             stored2;
  fetch_pkg::word_t word_a;
  fetch_pkg::word_t word_b;
  logic [15:0]      upper;

  // word holding paddr and the one after it.
  assign tag_a = paddr[31:2];
  assign tag_b = tag_a + fetch_pkg::tag_t'(1);

  assign rd.ridx = paddr[fetch_pkg::PF_DEPTH+1:2];

  // a valid write in flight for the same word.
  assign byp1 = byp.wren && byp.wvalid && (byp.wtag == tag_a);
  assign byp2 = byp.wren && byp.wvalid && (byp.wtag == tag_b);

  assign stored1 = rd.valid1 && (rd.tag1 == tag_a);
  assign stored2 = rd.valid2 && (rd.tag2 == tag_b);

  assign hit1 = byp1 || stored1;
  assign hit2 = byp2 || stored2;

  // write data wins over the stored copy.
  assign word_a = byp1 ? byp.wword : rd.word1;
  assign word_b = byp2 ? byp.wword : rd.word2;

  assign upper = word_a[31:16];

  always_comb begin
    if (!paddr[1]) begin
      parcel = word_a;
      parcel_ok = hit1;
    end else if (upper[1:0] != 2'b11) begin
      // compressed, low half only.
      parcel = {16'h0000, upper};
      parcel_ok = hit1;
    end else begin
      // 32-bit parcel straddling two words.
      parcel = {word_b[15:0], upper};
      parcel_ok = hit1 && hit2;
    end
  end

  assign step = (parcel[1:0] == 2'b11) ? fetch_pkg::step_t'(2) : fetch_pkg::step_t'(1);

endmodule

// ==== hw/prefetch_ctrl.sv ====
`timescale 1ns/1ns

module prefetch_ctrl (
  input  logic             clk,
  input  logic             rst,
  input  logic             fetch_valid,
  input  logic             fetch_fence,
  input  fetch_pkg::addr_t fetch_addr,
  output logic             fetch_ready,
  output fetch_pkg::word_t fetch_rdata,
  output logic             mem_valid,
  output fetch_pkg::addr_t mem_addr,
  input  logic             mem_ready,
  input  fetch_pkg::word_t mem_rdata,
  pf_wr_if.master          wr,
  output fetch_pkg::addr_t paddr,
  input  logic             hit1,
  input  logic             hit2,
  input  logic             parcel_ok,
  input  fetch_pkg::step_t step,
  input  fetch_pkg::word_t parcel
);

  fetch_pkg::ctrl_state_t state;
  fetch_pkg::addr_t       paddr_q;
  logic                   pend_q;
  fetch_pkg::idx_t        sweep_q;
  fetch_pkg::credit_t     credit;
  fetch_pkg::credit_t     credit_sum;
  fetch_pkg::credit_t     credit_next;
  fetch_pkg::tag_t        miss_tag;
  logic                   fence_req;
  logic                   fetch_req;
  logic                   pend;
  logic                   in_run;
  logic                   resp_wr;
  logic                   redirect;
  logic                   sweep_last;

  assign fence_req = fetch_valid && fetch_fence;
  assign fetch_req = fetch_valid && !fetch_fence;
  assign in_run = (state == fetch_pkg::RUN) && !fence_req;

  // a new request is looked up in the same cycle.
  assign pend = fetch_req || pend_q;
  assign paddr = fetch_req ? fetch_addr : paddr_q;

  assign resp_wr = in_run && mem_ready;
  assign fetch_ready = in_run && pend && parcel_ok;
  assign fetch_rdata = parcel;

  // back-pressure once the buffer runs far enough ahead.
  assign mem_valid = credit < fetch_pkg::credit_t'(fetch_pkg::PF_ENTRIES - 1);

  // only at a response or with no request out, so mem_addr stays put mid-request.
  assign redirect = in_run && pend && !parcel_ok && (mem_ready || !mem_valid);

  // first word of the parcel that is missing.
  assign miss_tag = (hit1 && !hit2) ? paddr[31:2] + fetch_pkg::tag_t'(1) : paddr[31:2];

  assign sweep_last = (sweep_q == fetch_pkg::idx_t'(fetch_pkg::PF_ENTRIES - 1));

  always_comb begin
    wr.wren = resp_wr;
    wr.widx = mem_addr[fetch_pkg::PF_DEPTH+1:2];
    wr.wvalid = resp_wr;
    wr.wtag = mem_addr[31:2];
    wr.wword = mem_rdata;
    if (fence_req) begin
      wr.wren = 1'b1;
      wr.widx = '0;
    end else if ((state == fetch_pkg::FENCE) && !sweep_last) begin
      wr.wren = 1'b1;
      wr.widx = sweep_q + fetch_pkg::idx_t'(1);
    end
  end

  always_comb begin
    credit_sum = resp_wr ? credit + fetch_pkg::credit_t'(2) : credit;
    credit_next = credit_sum;
    // never below zero.
    if (fetch_ready && (fetch_pkg::credit_t'(step) <= credit_sum)) begin
      credit_next = credit_sum - fetch_pkg::credit_t'(step);
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_req) begin
      paddr_q <= fetch_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= fetch_pkg::RUN;
      mem_addr <= '0;
      credit <= '0;
      pend_q <= 1'b0;
      sweep_q <= '0;
    end else begin
      pend_q <= pend && !fetch_ready && !fence_req;
      if (fence_req) begin
        // sweep starts at index 0 in the request cycle.
        state <= fetch_pkg::FENCE;
        sweep_q <= '0;
        credit <= '0;
      end else if (state == fetch_pkg::FENCE) begin
        if (!sweep_last) begin
          sweep_q <= sweep_q + fetch_pkg::idx_t'(1);
        end else if (mem_ready) begin
          // response dropped, the same address is asked again.
          state <= fetch_pkg::RUN;
        end
      end else if (redirect) begin
        mem_addr <= {miss_tag, 2'b00};
        credit <= '0;
      end else begin
        credit <= credit_next;
        if (resp_wr) begin
          mem_addr <= mem_addr + fetch_pkg::addr_t'(4);
        end
      end
    end
  end

  mem_addr_stable: assert property (@(posedge clk) disable iff (!rst)
    mem_valid && !mem_ready |=> $stable(mem_addr));

  no_ready_in_fence: assert property (@(posedge clk) disable iff (!rst)
    (state == fetch_pkg::FENCE) |-> !fetch_ready);

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit (
  input  logic             clk,
  input  logic             rst,
  // core side.
  input  logic             fetch_valid,
  input  logic             fetch_fence,
  input  fetch_pkg::addr_t fetch_addr,
  output logic             fetch_ready,
  output fetch_pkg::word_t fetch_rdata,
  // instruction memory side.
  output logic             mem_valid,
  output fetch_pkg::addr_t mem_addr,
  input  logic             mem_ready,
  input  fetch_pkg::word_t mem_rdata
);

  fetch_pkg::addr_t paddr;
  logic             hit1;
  logic             hit2;
  logic             parcel_ok;
  fetch_pkg::step_t step;
  fetch_pkg::word_t parcel;

  pf_wr_if wr_bus ();
  pf_rd_if rd_bus ();

  prefetch_ctrl ctrl0 (
    .clk         (clk),
    .rst         (rst),
    .fetch_valid (fetch_valid),
    .fetch_fence (fetch_fence),
    .fetch_addr  (fetch_addr),
    .fetch_ready (fetch_ready),
    .fetch_rdata (fetch_rdata),
    .mem_valid   (mem_valid),
    .mem_addr    (mem_addr),
    .mem_ready   (mem_ready),
    .mem_rdata   (mem_rdata),
    .wr          (wr_bus.master),
    .paddr       (paddr),
    .hit1        (hit1),
    .hit2        (hit2),
    .parcel_ok   (parcel_ok),
    .step        (step),
    .parcel      (parcel)
  );

  prefetch_buffer buf0 (
    .clk (clk),
    .rst (rst),
    .wr  (wr_bus.target),
    .rd  (rd_bus.store)
  );

  // sees the write port for same-cycle bypass.
  fetch_aligner align0 (
    .paddr     (paddr),
    .rd        (rd_bus.reader),
    .byp       (wr_bus.monitor),
    .hit1      (hit1),
    .hit2      (hit2),
    .parcel_ok (parcel_ok),
    .step      (step),
    .parcel    (parcel)
  );

endmodule

// ==== sim/fetch_tb.sv ====
`timescale 1ns/1ns

module fetch_tb;

  localparam int CYCLES_PER_LINE = 64;

  logic                   clk;
  logic                   rst;
  logic                   fetch_valid;
  logic                   fetch_fence;
  fetch_pkg::addr_t       fetch_addr;
  logic                   fetch_ready;
  fetch_pkg::word_t       fetch_rdata;
  logic                   mem_valid;
  fetch_pkg::addr_t       mem_addr;
  logic                   mem_ready = 1'b0;
  fetch_pkg::word_t       mem_rdata = '0;

  // memory image, indexed by word-aligned byte address.
  logic [31:0]            mem_img [logic [31:0]];
  byte                    cmd_q [$];
  logic [31:0]            arg_a [$];
  logic [31:0]            arg_d [$];

  int                     errors = 0;
  int                     checks = 0;
  int                     cycles = 0;
  int                     cycle_limit = 0;
  logic [31:0]            rng = 32'hf685ed4f;
  logic [1:0]             wait_cnt = 2'd0;
  logic                   mv_s = 1'b0;
  logic [31:0]            ma_s = '0;
  logic [31:0]            last_addr = '0;
  logic                   stim_ok;

  fetch_unit dut0 (
    .clk         (clk),
    .rst         (rst),
    .fetch_valid (fetch_valid),
    .fetch_fence (fetch_fence),
    .fetch_addr  (fetch_addr),
    .fetch_ready (fetch_ready),
    .fetch_rdata (fetch_rdata),
    .mem_valid   (mem_valid),
    .mem_addr    (mem_addr),
    .mem_ready   (mem_ready),
    .mem_rdata   (mem_rdata)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // words never loaded read back as a pattern of their address.
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [31:0] wa;
    wa = {addr[31:2], 2'b00};
    if (mem_img.exists(wa)) begin
      return mem_img[wa];
    end
    return {wa[15:0], wa[31:16]} ^ 32'h3c5a96e1;
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic load_stim(output logic ok);
    int          fd;
    int          n;
    string       tok;
    string       rest;
    logic [31:0] a;
    logic [31:0] d;
    ok = 1'b1;
    fd = $fopen("sim/fetch_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/fetch_stim.txt");
      ok = 1'b0;
      return;
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, " %s", tok);
      if (n != 1) begin
        break;
      end
      if (tok[0] == "#") begin
        n = $fgets(rest, fd);
      end else if (tok == "m" || tok == "f" || tok == "w") begin
        n = $fscanf(fd, " %h %h", a, d);
        cmd_q.push_back(tok[0]);
        arg_a.push_back(a);
        arg_d.push_back(d);
      end else if (tok == "c") begin
        cmd_q.push_back(tok[0]);
        arg_a.push_back('0);
        arg_d.push_back('0);
      end else begin
        $display("unknown line type %s in the stimulus file", tok);
        ok = 1'b0;
      end
    end
    $fclose(fd);
  endtask

  // drop the request after its first cycle, then wait for fetch_ready.
  task automatic issue_fetch(input logic [31:0] a, input logic [31:0] exp);
    logic        got;
    logic [31:0] data;
    got = 1'b0;
    data = '0;
    last_addr = a;
    @(posedge clk);
    fetch_valid <= 1'b1;
    fetch_fence <= 1'b0;
    fetch_addr <= a;
    while (!got) begin
      @(negedge clk);
      if (fetch_ready) begin
        got = 1'b1;
        data = fetch_rdata;
      end
      @(posedge clk);
      fetch_valid <= 1'b0;
    end
    check_val($sformatf("fetch at %08h", a), data, exp);
  endtask

  // fence, then ask again for the last fetched word while the sweep runs.
  task automatic fence_buffer();
    logic        swept;
    logic        got;
    int          n;
    logic [31:0] wa;
    logic [31:0] data;
    swept = 1'b0;
    got = 1'b0;
    n = 0;
    wa = {last_addr[31:2], 2'b00};
    data = '0;
    @(posedge clk);
    fetch_valid <= 1'b1;
    fetch_fence <= 1'b1;
    @(posedge clk);
    fetch_fence <= 1'b0;
    fetch_addr <= wa;
    while (!got) begin
      @(negedge clk);
      n++;
      if (!swept) begin
        check_val("fetch_ready during fence", {31'b0, fetch_ready}, 32'd0);
        // the sweep ends with the first memory response after its last write.
        swept = (n >= fetch_pkg::PF_ENTRIES) && mem_ready;
      end else if (fetch_ready) begin
        got = 1'b1;
        data = fetch_rdata;
      end
      @(posedge clk);
      fetch_valid <= 1'b0;
    end
    check_val($sformatf("fetch at %08h after fence", wa), data, read_word(wa));
  endtask

  // memory model samples at the falling edge and answers on the rising edge.
  always @(negedge clk) begin
    mv_s <= mem_valid;
    ma_s <= mem_addr;
  end

  always @(posedge clk) begin
    if (!rst) begin
      mem_ready <= 1'b0;
      mem_rdata <= '0;
    end else begin
      mem_ready <= 1'b0;
      if (mv_s && !mem_ready) begin
        if (wait_cnt == 2'd0) begin
          mem_ready <= 1'b1;
          mem_rdata <= read_word(ma_s);
          rng = xorshift(rng);
          wait_cnt = rng[1:0];
        end else begin
          wait_cnt = wait_cnt - 2'd1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the fetch unit stopped answering", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    rst = 1'b0;
    fetch_valid = 1'b0;
    fetch_fence = 1'b0;
    fetch_addr = '0;
    load_stim(stim_ok);
    if (!stim_ok) begin
      $display("stimulus file could not be read");
      $display(">>> FAIL");
      $finish;
    end else begin
      cycle_limit = CYCLES_PER_LINE * (cmd_q.size() + 1) + 20;
      repeat (10) @(posedge clk);
      rst <= 1'b1;
      // fetching starts at address 0 with nothing delivered.
      @(negedge clk);
      check_val("fetch_ready after reset", {31'b0, fetch_ready}, 32'd0);
      check_val("mem_valid after reset", {31'b0, mem_valid}, 32'd1);
      check_val("mem_addr after reset", mem_addr, 32'd0);
      foreach (cmd_q[i]) begin
        case (cmd_q[i])
          "m": mem_img[{arg_a[i][31:2], 2'b00}] = arg_d[i];
          "w": mem_img[{arg_a[i][31:2], 2'b00}] = arg_d[i];
          "f": issue_fetch(arg_a[i], arg_d[i]);
          "c": fence_buffer();
          default: $display("skipped an unknown command");
        endcase
      end
      @(posedge clk);
      $display("fetch_tb done: %0d errors in %0d checks", errors, checks);
      if (errors == 0) begin
        $display(">>> PASS");
      end else begin
        $display(">>> FAIL");
      end
      $finish;
    end
  end

endmodule

// ==== fetch.f ====
hw/fetch_pkg.sv
hw/pf_wr_if.sv
hw/pf_rd_if.sv
hw/prefetch_buffer.sv
hw/fetch_aligner.sv
hw/prefetch_ctrl.sv
hw/fetch_unit.sv
sim/fetch_tb.sv

// ==== Makefile ====
# Verilator build and run for the fetch unit testbench.

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= fetch.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail.
run: compile
	./$(BINARY) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/fetch_stim.txt ====
# m addr data: load memory; f addr expected: fetch and check the parcel
# w addr data: change memory; c: fence the prefetch buffer
m 00000000 00500093
m 00000004 00a00113
m 00000008 002081b3
m 0000000c 40110233
m 00000010 04054505
m 00000014 00938082
m 00000018 12340050
m 0000001c 00c00193
m 00000020 00b00213
m 00000024 45854501
m 00000028 0ff00293
m 0000002c 00008082
m 00000030 00000013
m 00000034 00000013
m 00000200 06400513
m 00000204 fff50513
m 00000208 fe051ee3
m 0000020c 00008067
# sequential 32-bit words
f 00000000 00500093
f 00000004 00a00113
f 00000008 002081b3
f 0000000c 40110233
# compressed parcels and straddling words
f 00000010 04054505
f 00000012 00000405
f 00000014 00938082
f 00000016 00500093
f 0000001a 00001234
f 0000001c 00c00193
f 00000020 00b00213
f 00000024 45854501
f 00000026 00004585
f 00000028 0ff00293
f 0000002e 00000000
# far jump and back
f 00000200 06400513
f 00000204 fff50513
f 00000206 0000fff5
f 00000208 fe051ee3
f 0000020a 0000fe05
f 0000020c 00008067
f 00000008 002081b3
f 00000016 00500093
f 00000030 00000013
f 00000002 00000050
# memory change, then fence
f 00000004 00a00113
w 00000004 00100073
c
f 00000004 00100073
f 00000000 00500093
f 00000006 00000010
f 00000200 06400513
w 00000200 00000297
c
f 00000200 00000297
f 0000001e 000000c0
f 0000020c 00008067
f 00000202 00000000
f 00000204 fff50513
